// File: files.f
imuldiv_pkg.sv
int_mul_dpath.sv
int_mul_ctrl.sv
int_mul_iterative.sv
int_div_iterative.sv
imuldiv_unit.sv
imuldiv_unit_tb.sv

// File: imuldiv_pkg.sv
//--------------------------------------
// shared width, function codes and
// request structs for the muldiv unit
//--------------------------------------

package imuldiv_pkg;

  // operand width, fixed so the structs below have a set size
  localparam int xlen = 32;

  //--------------------------------------
  // function codes
  //--------------------------------------

  // 2-bit code carried on the request port
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } muldiv_fn_e;

  //--------------------------------------
  // messages
  //--------------------------------------

  // outside request, 66 bits
  typedef struct packed {
    muldiv_fn_e      fn;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } muldiv_req_t;

  // operand pair handed to either engine, 64 bits
  typedef struct packed {
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } mul_req_t;

endpackage

// File: imuldiv_unit.sv
//--------------------------------------
// muldiv top, dispatch to one engine
// and return its response
//--------------------------------------

`timescale 1ns/1ns

module imuldiv_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_pkg::muldiv_req_t req_msg,
  input  logic                     req_val,
  output logic                     req_rdy,
  output logic [63:0]              resp_msg,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  logic                    in_flight;
  imuldiv_pkg::muldiv_fn_e fn_q;
  logic                    req_go;
  logic                    resp_go;
  logic                    sel_mul;

  imuldiv_pkg::mul_req_t   op;
  logic                    is_mul;

  // engine ports
  logic                    mul_req_val;
  logic                    mul_req_rdy;
  logic [63:0]             mul_resp_msg;
  logic                    mul_resp_val;
  logic                    mul_resp_rdy;
  logic                    div_req_val;
  logic                    div_req_rdy;
  logic [63:0]             div_resp_msg;
  logic                    div_resp_val;
  logic                    div_resp_rdy;

  //--------------------------------------
  // dispatch
  //--------------------------------------

  // one operation at a time
  assign req_rdy = !in_flight;
  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  assign op.a   = req_msg.a;
  assign op.b   = req_msg.b;
  assign is_mul = (req_msg.fn == imuldiv_pkg::fn_mul);

  // steer the request straight through, engine accepts on the same edge
  assign mul_req_val = req_val && !in_flight && is_mul;
  assign div_req_val = req_val && !in_flight && !is_mul;

  // track what is in flight
  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= 1'b0;
    end else if (req_go) begin
      in_flight <= 1'b1;
    end else if (resp_go) begin
      in_flight <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_go) begin
      fn_q <= req_msg.fn;
    end
  end

  //--------------------------------------
  // response selection
  //--------------------------------------

  assign sel_mul      = (fn_q == imuldiv_pkg::fn_mul);
  assign resp_msg     = sel_mul ? mul_resp_msg : div_resp_msg;
  assign resp_val     = sel_mul ? mul_resp_val : div_resp_val;
  assign mul_resp_rdy = resp_rdy && sel_mul;
  assign div_resp_rdy = resp_rdy && !sel_mul;

  int_mul_iterative mul (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (op),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_msg (mul_resp_msg),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  int_div_iterative div (
    .clk       (clk),
    .reset     (reset),
    .req_msg   (op),
    .is_signed (req_msg.fn == imuldiv_pkg::fn_div),
    .req_val   (div_req_val),
    .req_rdy   (div_req_rdy),
    .resp_msg  (div_resp_msg),
    .resp_val  (div_resp_val),
    .resp_rdy  (div_resp_rdy)
  );

  // a response only comes back for an accepted request
  assert property (@(posedge clk) disable iff (reset) resp_val |-> in_flight);

  // with nothing in flight both engines must be back in idle
  assert property (@(posedge clk) disable iff (reset)
    !in_flight |-> (mul_req_rdy && div_req_rdy));

endmodule

// File: imuldiv_unit_tb.sv
//----------------------------------------
// directed testbench for the muldiv unit
// reference model, tests and run limit
//----------------------------------------

`timescale 1ns/1ns

module imuldiv_unit_tb;

  // about 70 operations at 34 cycles, plus stalls, reset and margin
  localparam int cycle_limit = 5000;
  localparam int op_latency  = 33;
  localparam int op_cycles   = 34;

  logic                     clk;
  logic                     reset;
  imuldiv_pkg::muldiv_req_t req_msg;
  logic                     req_val;
  logic                     req_rdy;
  logic [63:0]              resp_msg;
  logic                     resp_val;
  logic                     resp_rdy;

  int          mismatch_count;
  int          other_count;
  int          cycle_count = 0;
  logic [31:0] lcg_state;

  imuldiv_unit dut (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not end within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  //----------------------------------------
  // helpers
  //----------------------------------------

  // inputs change 2 ns after the edge, outputs are settled there too
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // reference model: signed product, or {remainder, quotient}
  function automatic logic [63:0] expected_resp(input imuldiv_pkg::muldiv_fn_e fn,
                                                input logic [31:0] a,
                                                input logic [31:0] b);
    longint      sa;
    longint      sb;
    logic [31:0] q;
    logic [31:0] r;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    if (fn == imuldiv_pkg::fn_mul) begin
      return sa * sb;
    end
    // zero divisor gives all ones and hands back the dividend
    if (b == 32'd0) begin
      q = '1;
      r = a;
    end else if (fn == imuldiv_pkg::fn_div) begin
      // truncating divide, remainder keeps the dividend sign
      q = 32'(sa / sb);
      r = 32'(sa % sb);
    end else begin
      q = a / b;
      r = a % b;
    end
    return {r, q};
  endfunction

  // random operand pair, b shortened so quotients are not trivial
  task automatic draw_operands(input bit arith, output logic [31:0] a,
                               output logic [31:0] b);
    lcg_state = lcg_next(lcg_state);
    a         = lcg_state;
    lcg_state = lcg_next(lcg_state);
    if (arith) begin
      b = $signed(lcg_state) >>> lcg_state[3:0];
    end else begin
      b = lcg_state >> lcg_state[3:0];
    end
  endtask

  // one operation: send, wait, optionally stall, check, release
  task automatic run_op(input string name, input imuldiv_pkg::muldiv_fn_e fn,
                        input logic [31:0] a, input logic [31:0] b, input int hold);
    logic [63:0] exp;
    logic [63:0] held;
    int          lat;
    int          i;
    exp        = expected_resp(fn, a, b);
    req_msg.fn = fn;
    req_msg.a  = a;
    req_msg.b  = b;
    req_val    = 1'b1;
    resp_rdy   = (hold == 0);
    while (!req_rdy) begin
      next_cycle();
    end
    // accepting edge
    next_cycle();
    req_val = 1'b0;
    lat     = 1;
    while (!resp_val) begin
      if (req_rdy) begin
        $display("%s: req_rdy went high while an operation was in flight", name);
        other_count++;
      end
      next_cycle();
      lat++;
    end
    if (lat != op_latency) begin
      $display("Mismatch in %s latency: expected %0d, actual %0d", name, op_latency, lat);
      mismatch_count++;
    end
    // back-pressure, response and req_rdy must not move
    held = resp_msg;
    for (i = 0; i < hold; i++) begin
      next_cycle();
      if (!resp_val || req_rdy || resp_msg !== held) begin
        $display("%s: response did not hold while resp_rdy was low", name);
        other_count++;
      end
    end
    resp_rdy = 1'b1;
    if (resp_msg !== exp) begin
      $display("Mismatch in %s (fn %0d a %h b %h): expected %h, actual %h",
               name, fn, a, b, exp, resp_msg);
      mismatch_count++;
    end
    // transfer edge, then the unit is free again
    next_cycle();
    if (!req_rdy || resp_val) begin
      $display("%s: unit did not return to idle after the response", name);
      other_count++;
    end
  endtask

  //----------------------------------------
  // tests
  //----------------------------------------

  task automatic test_reset_state();
    if (!req_rdy || resp_val) begin
      $display("Mismatch in reset: expected req_rdy 1 resp_val 0, actual req_rdy %b resp_val %b",
               req_rdy, resp_val);
      mismatch_count++;
    end
  endtask

  task automatic test_mul();
    logic [31:0] a;
    logic [31:0] b;
    int          i;
    run_op("mul", imuldiv_pkg::fn_mul, 32'd0, 32'd12345, 0);
    run_op("mul", imuldiv_pkg::fn_mul, 32'd1, 32'hdead_beef, 0);
    run_op("mul", imuldiv_pkg::fn_mul, 32'hffff_ffff, 32'd7, 0);
    run_op("mul", imuldiv_pkg::fn_mul, 32'hffff_ffff, 32'hffff_ffff, 0);
    run_op("mul", imuldiv_pkg::fn_mul, 32'hffff_fffd, 32'd9, 0);
    run_op("mul", imuldiv_pkg::fn_mul, 32'd6, 32'hffff_fff7, 0);
    run_op("mul", imuldiv_pkg::fn_mul, 32'hffff_fffc, 32'hffff_fffb, 0);
    // most negative value on one and both sides
    run_op("mul", imuldiv_pkg::fn_mul, 32'h8000_0000, 32'd1, 0);
    run_op("mul", imuldiv_pkg::fn_mul, 32'h8000_0000, 32'h8000_0000, 0);
    run_op("mul", imuldiv_pkg::fn_mul, 32'h7fff_ffff, 32'h8000_0000, 0);
    for (i = 0; i < 16; i++) begin
      draw_operands(1'b1, a, b);
      run_op("mul", imuldiv_pkg::fn_mul, a, b, 0);
    end
  endtask

  task automatic test_div();
    logic [31:0] a;
    logic [31:0] b;
    int          i;
    run_op("div", imuldiv_pkg::fn_div, 32'd100, 32'd7, 0);
    run_op("div", imuldiv_pkg::fn_div, 32'hffff_ff9c, 32'd7, 0);
    run_op("div", imuldiv_pkg::fn_div, 32'd100, 32'hffff_fff9, 0);
    run_op("div", imuldiv_pkg::fn_div, 32'hffff_ff9c, 32'hffff_fff9, 0);
    run_op("div", imuldiv_pkg::fn_div, 32'd7, 32'd100, 0);
    run_op("div", imuldiv_pkg::fn_div, 32'hffff_ffff, 32'd2, 0);
    // overflow case wraps back to the most negative value
    run_op("div", imuldiv_pkg::fn_div, 32'h8000_0000, 32'hffff_ffff, 0);
    run_op("div", imuldiv_pkg::fn_div, 32'h8000_0000, 32'd1, 0);
    for (i = 0; i < 12; i++) begin
      draw_operands(1'b1, a, b);
      run_op("div", imuldiv_pkg::fn_div, a, b, 0);
    end
  endtask

  task automatic test_divu();
    logic [31:0] a;
    logic [31:0] b;
    int          i;
    run_op("divu", imuldiv_pkg::fn_divu, 32'd100, 32'd7, 0);
    run_op("divu", imuldiv_pkg::fn_divu, 32'hffff_ffff, 32'd1, 0);
    run_op("divu", imuldiv_pkg::fn_divu, 32'hffff_ffff, 32'h10, 0);
    run_op("divu", imuldiv_pkg::fn_divu, 32'd3, 32'hffff_ffff, 0);
    // divide by zero
    run_op("divu", imuldiv_pkg::fn_divu, 32'd5, 32'd0, 0);
    run_op("divu", imuldiv_pkg::fn_divu, 32'h8000_0000, 32'd0, 0);
    for (i = 0; i < 12; i++) begin
      draw_operands(1'b0, a, b);
      run_op("divu", imuldiv_pkg::fn_divu, a, b, 0);
    end
  endtask

  task automatic test_back_pressure();
    run_op("back_pressure", imuldiv_pkg::fn_mul, 32'hffff_fff3, 32'd1000, 10);
    run_op("back_pressure", imuldiv_pkg::fn_div, 32'hffff_fc18, 32'd33, 10);
  endtask

  // back to back, each op should cost the minimum 34 cycles
  task automatic test_mixed();
    logic [31:0]             a;
    logic [31:0]             b;
    imuldiv_pkg::muldiv_fn_e fn;
    int                      start;
    int                      i;
    start = cycle_count;
    for (i = 0; i < 6; i++) begin
      case (i % 3)
        0:       fn = imuldiv_pkg::fn_mul;
        1:       fn = imuldiv_pkg::fn_div;
        default: fn = imuldiv_pkg::fn_divu;
      endcase
      draw_operands(fn != imuldiv_pkg::fn_divu, a, b);
      run_op("mixed", fn, a, b, 0);
    end
    if (cycle_count - start != 6 * op_cycles) begin
      $display("Mismatch in mixed cycle count: expected %0d, actual %0d",
               6 * op_cycles, cycle_count - start);
      mismatch_count++;
    end
  endtask

  //----------------------------------------
  // main sequence
  //----------------------------------------

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    req_val        = 1'b0;
    req_msg        = '0;
    resp_rdy       = 1'b1;
    mismatch_count = 0;
    other_count    = 0;
    lcg_state      = 32'he470;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    test_reset_state();
    test_mul();
    test_div();
    test_divu();
    test_back_pressure();
    test_mixed();
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count + other_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: int_div_iterative.sv
//--------------------------------------
// iterative restoring divider
// signed or unsigned with quotient and rem
//--------------------------------------

`timescale 1ns/1ns

module int_div_iterative (
  input  logic                  clk,
  input  logic                  reset,
  input  imuldiv_pkg::mul_req_t req_msg,
  input  logic                  is_signed,
  input  logic                  req_val,
  output logic                  req_rdy,
  output logic [63:0]           resp_msg,
  output logic                  resp_val,
  input  logic                  resp_rdy
);

  typedef enum logic [1:0] {
    state_idle = 2'd0,
    state_calc = 2'd1,
    state_done = 2'd2
  } state_e;

  state_e      state;
  logic        req_go;
  logic        resp_go;

  // working registers
  logic [31:0] rem_q;
  logic [31:0] quot_q;
  logic [31:0] divisor_q;
  logic [4:0]  cnt_q;
  logic        neg_quot_q;
  logic        neg_rem_q;

  logic        a_neg;
  logic        b_neg;
  logic [31:0] a_mag;
  logic [31:0] b_mag;
  logic [32:0] rem_shift;
  logic [33:0] diff;
  logic [31:0] quot_out;
  logic [31:0] rem_out;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  //--------------------------------------
  // operand conditioning
  //--------------------------------------

  // only signed divides look at the sign bits
  assign a_neg = is_signed && req_msg.a[31];
  assign b_neg = is_signed && req_msg.b[31];
  assign a_mag = a_neg ? (~req_msg.a + 32'd1) : req_msg.a;
  assign b_mag = b_neg ? (~req_msg.b + 32'd1) : req_msg.b;

  //--------------------------------------
  // one restoring step
  //--------------------------------------

  // remainder with the next dividend bit shifted in
  assign rem_shift = {rem_q, quot_q[31]};
  // borrow out in bit 33 means the divisor did not fit
  assign diff      = {1'b0, rem_shift} - {2'b00, divisor_q};

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= state_idle;
    end else begin
      case (state)
        state_idle: if (req_go) state <= state_calc;
        state_calc: if (cnt_q == 5'd0) state <= state_done;
        state_done: if (resp_go) state <= state_idle;
        default:    state <= state_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_go) begin
      rem_q      <= 32'd0;
      quot_q     <= a_mag;
      divisor_q  <= b_mag;
      cnt_q      <= 5'd31;
      // a zero divisor keeps the all-ones quotient unsigned
      neg_quot_q <= (a_neg ^ b_neg) && (req_msg.b != 32'd0);
      // remainder follows the dividend
      neg_rem_q  <= a_neg;
    end else if (state == state_calc) begin
      if (!diff[33]) begin
        rem_q  <= diff[31:0];
        quot_q <= {quot_q[30:0], 1'b1};
      end else begin
        rem_q  <= rem_shift[31:0];
        quot_q <= {quot_q[30:0], 1'b0};
      end
      cnt_q <= cnt_q - 5'd1;
    end
  end

  //--------------------------------------
  // handshake and sign fix
  //--------------------------------------

  assign req_rdy  = (state == state_idle);
  assign resp_val = (state == state_done);

  assign quot_out = neg_quot_q ? (~quot_q + 32'd1) : quot_q;
  assign rem_out  = neg_rem_q ? (~rem_q + 32'd1) : rem_q;

  // remainder in the upper half and quotient in the lower half
  assign resp_msg = {rem_out, quot_out};

  // partial remainder stays below a nonzero divisor
  assert property (@(posedge clk) disable iff (reset)
    (state != state_idle) && (divisor_q != 32'd0) |-> (rem_q < divisor_q));

endmodule

// File: int_mul_ctrl.sv
//--------------------------------------
// multiplier control FSM
//--------------------------------------

`timescale 1ns/1ns

module int_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic a_sel,
  output logic b_en,
  output logic b_sel,
  output logic result_en,
  output logic result_sel,
  output logic cnt_sel,
  output logic sign_en,
  input  logic counter_is_zero,
  input  logic b_lsb
);

  typedef enum logic [1:0] {
    state_idle = 2'd0,
    state_calc = 2'd1,
    state_done = 2'd2
  } state_e;

  state_e state;
  logic   req_go;
  logic   resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  //--------------------------------------
  // state register
  //--------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= state_idle;
    end else begin
      case (state)
        state_idle: if (req_go) state <= state_calc;
        // counter runs 31 down to 0 over 32 calc cycles
        state_calc: if (counter_is_zero) state <= state_done;
        state_done: if (resp_go) state <= state_idle;
        default:    state <= state_idle;
      endcase
    end
  end

  //--------------------------------------
  // outputs
  //--------------------------------------

  always_comb begin
    req_rdy    = 1'b0;
    resp_val   = 1'b0;
    a_en       = 1'b0;
    a_sel      = 1'b0;
    b_en       = 1'b0;
    b_sel      = 1'b0;
    result_en  = 1'b0;
    result_sel = 1'b0;
    cnt_sel    = 1'b0;
    sign_en    = 1'b0;
    case (state)
      state_idle: begin
        req_rdy   = 1'b1;
        // req_rdy is high in idle so req_val alone marks the accepting edge
        // load operands and clear the result on that edge
        a_en      = req_val;
        b_en      = req_val;
        result_en = req_val;
        sign_en   = req_val;
      end
      state_calc: begin
        a_en       = 1'b1;
        a_sel      = 1'b1;
        b_en       = 1'b1;
        b_sel      = 1'b1;
        // accumulate only for a set multiplier bit
        result_en  = b_lsb;
        result_sel = 1'b1;
        cnt_sel    = 1'b1;
      end
      state_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

  // the datapath counter holds calc for exactly 32 cycles
  assert property (@(posedge clk) disable iff (reset)
    $fell(state == state_calc) |->
      $past(state == state_calc, 32) && !$past(state == state_calc, 33));

endmodule

// File: int_mul_dpath.sv
//--------------------------------------
// shift-and-add multiplier datapath
//--------------------------------------

`timescale 1ns/1ns

module int_mul_dpath (
  input  logic                  clk,
  input  logic                  reset,
  input  imuldiv_pkg::mul_req_t req_msg,
  input  logic                  a_en,
  input  logic                  a_sel,
  input  logic                  b_en,
  input  logic                  b_sel,
  input  logic                  result_en,
  input  logic                  result_sel,
  input  logic                  cnt_sel,
  input  logic                  sign_en,
  output logic                  counter_is_zero,
  output logic                  b_lsb,
  output logic [63:0]           result
);

  logic [63:0] a_reg;
  logic [31:0] b_reg;
  logic [63:0] result_reg;
  logic [4:0]  counter_reg;
  logic        sign_reg;

  logic [31:0] a_mag;
  logic [31:0] b_mag;
  logic [63:0] a_next;
  logic [31:0] b_next;
  logic [63:0] result_next;
  logic [4:0]  counter_next;

  // magnitudes of the signed operands
  // most negative value maps to 2^31, which still fits unsigned
  assign a_mag = req_msg.a[31] ? (~req_msg.a + 32'd1) : req_msg.a;
  assign b_mag = req_msg.b[31] ? (~req_msg.b + 32'd1) : req_msg.b;

  //--------------------------------------
  // next-value muxes
  //--------------------------------------

  // sel low loads, sel high steps
  assign a_next       = a_sel ? (a_reg << 1) : {32'd0, a_mag};
  assign b_next       = b_sel ? (b_reg >> 1) : b_mag;
  assign result_next  = result_sel ? (result_reg + a_reg) : 64'd0;
  assign counter_next = cnt_sel ? (counter_reg - 5'd1) : 5'd31;

  // iteration counter, reloaded whenever not counting down
  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg <= 5'd31;
    end else begin
      counter_reg <= counter_next;
    end
  end

  // operand and accumulator registers
  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
    if (b_en) begin
      b_reg <= b_next;
    end
    // add only happens when ctrl saw b_lsb set
    if (result_en) begin
      result_reg <= result_next;
    end
    if (sign_en) begin
      sign_reg <= req_msg.a[31] ^ req_msg.b[31];
    end
  end

  assign counter_is_zero = (counter_reg == 5'd0);
  assign b_lsb           = b_reg[0];

  // sign fix on the way out
  assign result = sign_reg ? (~result_reg + 64'd1) : result_reg;

endmodule

// File: int_mul_iterative.sv
//--------------------------------------
// iterative signed multiplier engine
//--------------------------------------

`timescale 1ns/1ns

module int_mul_iterative (
  input  logic                  clk,
  input  logic                  reset,
  input  imuldiv_pkg::mul_req_t req_msg,
  input  logic                  req_val,
  output logic                  req_rdy,
  output logic [63:0]           resp_msg,
  output logic                  resp_val,
  input  logic                  resp_rdy
);

  // ctrl to dpath
  logic a_en;
  logic a_sel;
  logic b_en;
  logic b_sel;
  logic result_en;
  logic result_sel;
  logic cnt_sel;
  logic sign_en;

  // dpath status back to ctrl
  logic counter_is_zero;
  logic b_lsb;

  int_mul_ctrl ctrl (
    .clk             (clk),
    .reset           (reset),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy),
    .a_en            (a_en),
    .a_sel           (a_sel),
    .b_en            (b_en),
    .b_sel           (b_sel),
    .result_en       (result_en),
    .result_sel      (result_sel),
    .cnt_sel         (cnt_sel),
    .sign_en         (sign_en),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb)
  );

  int_mul_dpath dpath (
    .clk             (clk),
    .reset           (reset),
    .req_msg         (req_msg),
    .a_en            (a_en),
    .a_sel           (a_sel),
    .b_en            (b_en),
    .b_sel           (b_sel),
    .result_en       (result_en),
    .result_sel      (result_sel),
    .cnt_sel         (cnt_sel),
    .sign_en         (sign_en),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb),
    .result          (resp_msg)
  );

endmodule

// File: run.sh
#!/bin/sh
# build the muldiv testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module imuldiv_unit_tb -o imuldiv_sim &&
./obj_dir/imuldiv_sim | tee /dev/stderr | grep -q "Finished with no errors" &&
echo "PASS" || { echo "FAIL"; exit 1; }
